//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and search the log for the result
rm -f sim.log \
  && verilator --binary --timing --assert -j 0 \
       --top-module tb_ntps_interfaces -f vlog.f -o sim_ntps \
  && { ./obj_dir/sim_ntps +verilator+error+limit+100 > sim.log 2>&1; \
       cat sim.log; \
       grep -qx "test passed" sim.log; } \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed, see sim.log"; exit 1; }

//--- source/apb_slave_decoder.sv
//------------------------------------------------
// APB slave-index decoder
// Per-slave psel gating, response multiplexing
// Error response for unmapped windows
//------------------------------------------------

`timescale 1ns/1ps

module apb_slave_decoder (
  input  logic               clk156,
  input  logic               rst_n,
  input  ntps_pkg::apb_req_t apb_req,
  output ntps_pkg::apb_rsp_t apb_rsp,
  output ntps_pkg::apb_req_t slv_req [ntps_pkg::NUM_SLAVES],
  input  ntps_pkg::apb_rsp_t slv_rsp [ntps_pkg::NUM_SLAVES]
);

  logic [ntps_pkg::SLV_IDX_W-1:0] slv_idx;
  logic                           unmapped;
  logic                           err_q;

  // Index field of the address
  assign slv_idx  = apb_req.paddr[ntps_pkg::SLV_IDX_LSB +: ntps_pkg::SLV_IDX_W];
  // Indices past the last window
  assign unmapped = (slv_idx >= ntps_pkg::SLV_IDX_W'(ntps_pkg::NUM_SLAVES));

  //------------------------------------------------
  // Request fan-out
  //------------------------------------------------
  always_comb begin
    for (int i = 0; i < ntps_pkg::NUM_SLAVES; i++) begin
      // Payload goes everywhere
      slv_req[i]      = apb_req;
      // Only the addressed slave sees psel
      slv_req[i].psel = apb_req.psel && (slv_idx == ntps_pkg::SLV_IDX_W'(i));
    end
  end

  //------------------------------------------------
  // Unmapped access tracking
  //------------------------------------------------
  // Armed in setup, live only in the first access cycle
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= apb_req.psel && !apb_req.penable && unmapped;
    end
  end

  //------------------------------------------------
  // Response mux
  //------------------------------------------------
  always_comb begin
    // Decoder's own error answer by default
    apb_rsp.pready  = err_q && apb_req.psel && apb_req.penable;
    apb_rsp.prdata  = '0;
    apb_rsp.pslverr = err_q && apb_req.psel && apb_req.penable;
    // Mapped window overrides
    for (int i = 0; i < ntps_pkg::NUM_SLAVES; i++) begin
      if (slv_idx == ntps_pkg::SLV_IDX_W'(i)) begin
        apb_rsp = slv_rsp[i];
      end
    end
  end

endmodule

//--- source/network_path_regs.sv
//------------------------------------------------
// Network-path register block
// GEN_CONFIG and STATUS registers
// Forwarding of the upper window to the API
// extension port with a wait/done FSM
//------------------------------------------------

`timescale 1ns/1ps

module network_path_regs (
  input  logic                         clk156,
  input  logic                         rst_n,
  input  ntps_pkg::apb_req_t           apb_req,
  output ntps_pkg::apb_rsp_t           apb_rsp,
  input  logic                         ntp_sync_ok,
  output logic [ntps_pkg::DATA_W-1:0]  gen_config,
  output ntps_pkg::api_ext_req_t       api_ext_req,
  input  ntps_pkg::api_ext_rsp_t       api_ext_rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_DONE
  } ext_state_t;

  ext_state_t                      state_q;
  logic [ntps_pkg::OFS_W-1:0]      ofs;
  logic                            ext_hit;
  logic                            access;
  logic [ntps_pkg::DATA_W-1:0]     reg_rdata;
  logic [1:0]                      cmd_q;
  logic [ntps_pkg::API_ADDR_W-1:0] addr_q;
  logic [ntps_pkg::DATA_W-1:0]     wdata_q;
  logic [ntps_pkg::DATA_W-1:0]     ext_rdata_q;
  logic                            ext_err_q;

  assign ofs     = apb_req.paddr[ntps_pkg::OFS_W-1:0];
  assign ext_hit = (ofs >= ntps_pkg::NP_EXT_BASE);
  assign access  = apb_req.psel && apb_req.penable;

  //------------------------------------------------
  // Local registers
  //------------------------------------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      gen_config <= '0;
    end else if (access && apb_req.pwrite && ofs == ntps_pkg::NP_GEN_CONFIG) begin
      gen_config <= apb_req.pwdata;
    end
  end

  // STATUS is read only
  always_comb begin
    case (ofs)
      ntps_pkg::NP_GEN_CONFIG: reg_rdata = gen_config;
      ntps_pkg::NP_STATUS:     reg_rdata = {{(ntps_pkg::DATA_W-1){1'b0}}, ntp_sync_ok};
      default:                 reg_rdata = '0;
    endcase
  end

  //------------------------------------------------
  // API extension FSM
  //------------------------------------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      cmd_q   <= ntps_pkg::API_CMD_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // Launch on the first access cycle
          if (access && ext_hit) begin
            cmd_q   <= apb_req.pwrite ? ntps_pkg::API_CMD_WRITE : ntps_pkg::API_CMD_READ;
            state_q <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          // Hold until the responder stops reporting busy
          if (api_ext_rsp.status != ntps_pkg::API_ST_BUSY) begin
            cmd_q   <= ntps_pkg::API_CMD_IDLE;
            state_q <= ST_DONE;
          end
        end
        // pready cycle
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Address, write data and result capture
  always_ff @(posedge clk156) begin
    if (state_q == ST_IDLE && access && ext_hit) begin
      addr_q  <= ntps_pkg::API_ADDR_W'(ofs);
      wdata_q <= apb_req.pwdata;
    end
    if (state_q == ST_WAIT && api_ext_rsp.status != ntps_pkg::API_ST_BUSY) begin
      ext_rdata_q <= api_ext_rsp.read_data;
      ext_err_q   <= (api_ext_rsp.status == ntps_pkg::API_ST_ERR);
    end
  end

  assign api_ext_req.command    = cmd_q;
  assign api_ext_req.address    = addr_q;
  assign api_ext_req.write_data = wdata_q;

  //------------------------------------------------
  // APB response
  //------------------------------------------------
  always_comb begin
    if (state_q == ST_DONE) begin
      apb_rsp.pready  = 1'b1;
      apb_rsp.prdata  = ext_rdata_q;
      apb_rsp.pslverr = ext_err_q;
    end else begin
      // Register window answers immediately
      apb_rsp.pready  = access && !ext_hit;
      apb_rsp.prdata  = reg_rdata;
      apb_rsp.pslverr = 1'b0;
    end
  end

endmodule

//--- source/ntp_clock_core.sv
//------------------------------------------------
// One NTP clock
// 64-bit timestamp counter with STEP increment
// APB registers: TIME_HI, TIME_LO, STEP, CTRL
//------------------------------------------------

`timescale 1ns/1ps

module ntp_clock_core (
  input  logic               clk156,
  input  logic               rst_n,
  input  ntps_pkg::apb_req_t apb_req,
  output ntps_pkg::apb_rsp_t apb_rsp,
  output ntps_pkg::ntp_src_t src
);

  logic [ntps_pkg::NTP_TIME_W-1:0] time_q;
  logic [ntps_pkg::DATA_W-1:0]     step_q;
  logic [ntps_pkg::DATA_W-1:0]     ctrl_q;
  logic [ntps_pkg::OFS_W-1:0]      ofs;
  logic                            access;
  logic                            wr;
  logic [ntps_pkg::DATA_W-1:0]     rdata;

  // Local offset only, index bits belong to the decoder
  assign ofs    = apb_req.paddr[ntps_pkg::OFS_W-1:0];
  // No wait states on this window
  assign access = apb_req.psel && apb_req.penable;
  assign wr     = access && apb_req.pwrite;

  //------------------------------------------------
  // Timestamp and control registers
  //------------------------------------------------
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      time_q <= '0;
      step_q <= '0;
      ctrl_q <= '0;
    end else begin
      // Load wins over the increment for that cycle
      if (wr && ofs == ntps_pkg::NTP_TIME_HI) begin
        time_q <= {apb_req.pwdata, time_q[ntps_pkg::DATA_W-1:0]};
      end else if (wr && ofs == ntps_pkg::NTP_TIME_LO) begin
        time_q <= {time_q[ntps_pkg::NTP_TIME_W-1:ntps_pkg::DATA_W], apb_req.pwdata};
      end else begin
        // Free-running advance
        time_q <= time_q + ntps_pkg::NTP_TIME_W'(step_q);
      end

      if (wr && ofs == ntps_pkg::NTP_STEP) begin
        step_q <= apb_req.pwdata;
      end
      if (wr && ofs == ntps_pkg::NTP_CTRL) begin
        ctrl_q <= apb_req.pwdata;
      end
    end
  end

  //------------------------------------------------
  // Readback
  //------------------------------------------------
  always_comb begin
    case (ofs)
      ntps_pkg::NTP_TIME_HI: rdata = time_q[ntps_pkg::NTP_TIME_W-1:ntps_pkg::DATA_W];
      ntps_pkg::NTP_TIME_LO: rdata = time_q[ntps_pkg::DATA_W-1:0];
      ntps_pkg::NTP_STEP:    rdata = step_q;
      ntps_pkg::NTP_CTRL:    rdata = ctrl_q;
      // Holes read as zero
      default:               rdata = '0;
    endcase
  end

  assign apb_rsp.pready  = access;
  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pslverr = 1'b0;

  // Source for the clock select
  assign src.timestamp = time_q;
  assign src.sync_ok   = ctrl_q[0];

endmodule

//--- source/ntp_clock_select.sv
//------------------------------------------------
// Common NTP clock select
// Registered A/B choice of time and sync status
//------------------------------------------------

`timescale 1ns/1ps

module ntp_clock_select (
  input  logic                            clk156,
  input  logic                            rst_n,
  input  logic                            clk_sel,
  input  ntps_pkg::ntp_src_t              src_a,
  input  ntps_pkg::ntp_src_t              src_b,
  output logic [ntps_pkg::NTP_TIME_W-1:0] ntp_time,
  output logic                            ntp_sync_ok
);

  logic sel_q;

  // Select flop, then output flop
  always_ff @(posedge clk156 or negedge rst_n) begin
    if (!rst_n) begin
      sel_q       <= 1'b0;
      ntp_time    <= '0;
      ntp_sync_ok <= 1'b0;
    end else begin
      sel_q <= clk_sel;
      // 0 picks clock A, 1 picks clock B
      if (sel_q) begin
        ntp_time    <= src_b.timestamp;
        ntp_sync_ok <= src_b.sync_ok;
      end else begin
        ntp_time    <= src_a.timestamp;
        ntp_sync_ok <= src_a.sync_ok;
      end
    end
  end

endmodule

//--- source/ntps_interfaces.sv
//------------------------------------------------
// Top level of the register fabric
// APB decoder, two NTP clocks, clock select
// Four network-path blocks with API ports
//------------------------------------------------

`timescale 1ns/1ps

module ntps_interfaces (
  input  logic                            clk156,
  input  logic                            rst_n,
  input  ntps_pkg::apb_req_t              apb_req,
  output ntps_pkg::apb_rsp_t              apb_rsp,
  output ntps_pkg::api_ext_req_t          api_ext_req [ntps_pkg::NUM_PORTS],
  input  ntps_pkg::api_ext_rsp_t          api_ext_rsp [ntps_pkg::NUM_PORTS],
  output logic [ntps_pkg::NTP_TIME_W-1:0] ntp_time,
  output logic                            ntp_sync_ok
);

  ntps_pkg::apb_req_t          slv_req [ntps_pkg::NUM_SLAVES];
  ntps_pkg::apb_rsp_t          slv_rsp [ntps_pkg::NUM_SLAVES];
  ntps_pkg::ntp_src_t          src_a;
  ntps_pkg::ntp_src_t          src_b;
  // Port 0 config drives the clock choice
  logic [ntps_pkg::DATA_W-1:0] gen_config_0;

  //------------------------------------------------
  // Input side
  //------------------------------------------------
  apb_slave_decoder u_decoder (
    .clk156  (clk156),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .slv_req (slv_req),
    .slv_rsp (slv_rsp)
  );

  //------------------------------------------------
  // NTP clocks and select
  //------------------------------------------------
  ntp_clock_core u_ntp_clock_a (
    .clk156  (clk156),
    .rst_n   (rst_n),
    .apb_req (slv_req[ntps_pkg::SLV_NTPA]),
    .apb_rsp (slv_rsp[ntps_pkg::SLV_NTPA]),
    .src     (src_a)
  );

  ntp_clock_core u_ntp_clock_b (
    .clk156  (clk156),
    .rst_n   (rst_n),
    .apb_req (slv_req[ntps_pkg::SLV_NTPB]),
    .apb_rsp (slv_rsp[ntps_pkg::SLV_NTPB]),
    .src     (src_b)
  );

  ntp_clock_select u_clock_select (
    .clk156      (clk156),
    .rst_n       (rst_n),
    .clk_sel     (gen_config_0[ntps_pkg::GEN_CFG_CLK_SEL_BIT]),
    .src_a       (src_a),
    .src_b       (src_b),
    .ntp_time    (ntp_time),
    .ntp_sync_ok (ntp_sync_ok)
  );

  //------------------------------------------------
  // Network-path blocks
  //------------------------------------------------
  for (genvar p = 0; p < ntps_pkg::NUM_PORTS; p++) begin : g_np
    if (p == 0) begin : g_sel_port
      network_path_regs u_np (
        .clk156      (clk156),
        .rst_n       (rst_n),
        .apb_req     (slv_req[ntps_pkg::SLV_NP0 + p]),
        .apb_rsp     (slv_rsp[ntps_pkg::SLV_NP0 + p]),
        .ntp_sync_ok (ntp_sync_ok),
        .gen_config  (gen_config_0),
        .api_ext_req (api_ext_req[p]),
        .api_ext_rsp (api_ext_rsp[p])
      );
    end else begin : g_plain_port
      // Config of the other ports has no consumer here
      network_path_regs u_np (
        .clk156      (clk156),
        .rst_n       (rst_n),
        .apb_req     (slv_req[ntps_pkg::SLV_NP0 + p]),
        .apb_rsp     (slv_rsp[ntps_pkg::SLV_NP0 + p]),
        .ntp_sync_ok (ntp_sync_ok),
        .gen_config  (),
        .api_ext_req (api_ext_req[p]),
        .api_ext_rsp (api_ext_rsp[p])
      );
    end
  end

endmodule

//--- source/ntps_pkg.sv
//------------------------------------------------
// Shared definitions for the NTP appliance fabric
// APB address map and slave indices
// NTP clock and network-path register offsets
// API extension codes and packed bus structs
//------------------------------------------------

package ntps_pkg;

  //------------------------------------------------
  // Counts and address decode
  //------------------------------------------------
  localparam int NUM_PORTS   = 4;
  localparam int NUM_SLAVES  = 6;

  // Slave windows, network paths follow NP0
  localparam int SLV_NTPA    = 0;
  localparam int SLV_NTPB    = 1;
  localparam int SLV_NP0     = 2;

  localparam int ADDR_W      = 16;
  localparam int DATA_W      = 32;

  // Slave index sits above the local byte offset
  localparam int SLV_IDX_LSB = 12;
  localparam int SLV_IDX_W   = 3;
  localparam int OFS_W       = SLV_IDX_LSB;

  //------------------------------------------------
  // NTP clock registers
  //------------------------------------------------
  localparam int NTP_TIME_W = 64;

  // Seconds half, then fraction half
  localparam logic [OFS_W-1:0] NTP_TIME_HI = 12'h000;
  localparam logic [OFS_W-1:0] NTP_TIME_LO = 12'h004;
  // Increment applied every clock
  localparam logic [OFS_W-1:0] NTP_STEP    = 12'h008;
  // Bit 0 is sync_ok
  localparam logic [OFS_W-1:0] NTP_CTRL    = 12'h00c;

  //------------------------------------------------
  // Network-path registers
  //------------------------------------------------
  localparam logic [OFS_W-1:0] NP_GEN_CONFIG = 12'h000;
  localparam logic [OFS_W-1:0] NP_STATUS     = 12'h004;
  // Everything from here up goes to the API extension
  localparam logic [OFS_W-1:0] NP_EXT_BASE   = 12'h100;

  localparam int GEN_CFG_CLK_SEL_BIT = 24;

  //------------------------------------------------
  // API extension codes
  //------------------------------------------------
  localparam int API_ADDR_W = 32;

  localparam logic [1:0] API_CMD_IDLE  = 2'd0;
  localparam logic [1:0] API_CMD_READ  = 2'd1;
  localparam logic [1:0] API_CMD_WRITE = 2'd2;

  localparam logic [1:0] API_ST_BUSY   = 2'd0;
  localparam logic [1:0] API_ST_OK     = 2'd1;
  localparam logic [1:0] API_ST_ERR    = 2'd2;

  // APB request, 51 bits
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  // APB response
  typedef struct packed {
    logic              pready;
    logic [DATA_W-1:0] prdata;
    logic              pslverr;
  } apb_rsp_t;

  // API extension command side
  typedef struct packed {
    logic [1:0]            command;
    logic [API_ADDR_W-1:0] address;
    logic [DATA_W-1:0]     write_data;
  } api_ext_req_t;

  typedef struct packed {
    logic [1:0]        status;
    logic [DATA_W-1:0] read_data;
  } api_ext_rsp_t;

  // One NTP time source
  typedef struct packed {
    logic [NTP_TIME_W-1:0] timestamp;
    logic                  sync_ok;
  } ntp_src_t;

endpackage

//--- tests/ntps_assert.sv
//------------------------------------------------
// Concurrent assertions for network_path_regs
// API command hold and release
// APB pready only inside the access phase
//------------------------------------------------

`timescale 1ns/1ps

module ntps_assert (
  input logic                   clk156,
  input logic                   rst_n,
  input ntps_pkg::apb_req_t     apb_req,
  input ntps_pkg::apb_rsp_t     apb_rsp,
  input ntps_pkg::api_ext_req_t api_ext_req,
  input ntps_pkg::api_ext_rsp_t api_ext_rsp
);

  int fail_cnt;

  initial fail_cnt = 0;

  // Command, address and data frozen while busy
  cmd_hold: assert property (@(posedge clk156) disable iff (!rst_n)
    (api_ext_req.command != ntps_pkg::API_CMD_IDLE &&
     api_ext_rsp.status == ntps_pkg::API_ST_BUSY) |=> $stable(api_ext_req))
    else begin
      $error("API command changed while the responder was busy");
      fail_cnt++;
    end

  // Command back to idle on the clock after a non-busy status
  cmd_release: assert property (@(posedge clk156) disable iff (!rst_n)
    (api_ext_req.command != ntps_pkg::API_CMD_IDLE &&
     api_ext_rsp.status != ntps_pkg::API_ST_BUSY)
    |=> (api_ext_req.command == ntps_pkg::API_CMD_IDLE))
    else begin
      $error("API command still active after the responder answered");
      fail_cnt++;
    end

  pready_in_access: assert property (@(posedge clk156) disable iff (!rst_n)
    apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
    else begin
      $error("pready outside an APB access phase");
      fail_cnt++;
    end

endmodule

bind network_path_regs ntps_assert u_assert (
  .clk156      (clk156),
  .rst_n       (rst_n),
  .apb_req     (apb_req),
  .apb_rsp     (apb_rsp),
  .api_ext_req (api_ext_req),
  .api_ext_rsp (api_ext_rsp)
);

//--- tests/tb_ntps_interfaces.sv
//------------------------------------------------
// Testbench for the NTP register fabric
// Clock, reset, APB driver, API responders
// Register model, reference function, checks
// Watchdog and closing summary
//------------------------------------------------

`timescale 1ns/1ps

module tb_ntps_interfaces;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 5;
  localparam int N_EXT      = 24;
  // Upper bound of APB accesses over all behaviors
  localparam int N_ACCESS   = 32 + 3 + 16 + N_EXT + 4;
  localparam int WATCHDOG_CYCLES = N_ACCESS * 20 + 200;

  // One command seen at an API port
  typedef struct packed {
    logic [1:0]             port;
    ntps_pkg::api_ext_req_t req;
  } ext_seen_t;

  // One completed APB access
  typedef struct packed {
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic [7:0]  waits;
  } apb_done_t;

  logic                   clk156;
  logic                   rst_n;
  ntps_pkg::apb_req_t     apb_req;
  ntps_pkg::apb_rsp_t     apb_rsp;
  ntps_pkg::api_ext_req_t api_ext_req [ntps_pkg::NUM_PORTS];
  ntps_pkg::api_ext_rsp_t api_ext_rsp [ntps_pkg::NUM_PORTS];
  logic [63:0]            ntp_time;
  logic                   ntp_sync_ok;

  // Register model with clock regs indexed {clock, offset[3:2]}
  logic [31:0] gen_cfg_m [ntps_pkg::NUM_PORTS];
  logic [31:0] ntp_reg_m [8];

  apb_done_t   done_q[$];
  ext_seen_t   seen_q[$];
  int unsigned resp_delay;
  int          err_cnt;
  int          chk_cnt;

  ntps_interfaces DUT (
    .clk156      (clk156),
    .rst_n       (rst_n),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp),
    .api_ext_req (api_ext_req),
    .api_ext_rsp (api_ext_rsp),
    .ntp_time    (ntp_time),
    .ntp_sync_ok (ntp_sync_ok)
  );

  initial clk156 = 1'b0;
  always #(CLK_PERIOD / 2) clk156 = ~clk156;

  //------------------------------------------------
  // Model helpers
  //------------------------------------------------
  function automatic logic [15:0] slv_addr(input logic [2:0] idx, input logic [11:0] ofs);
    return {1'b0, idx, ofs};
  endfunction

  // Responder data pattern tagged with port and offset
  function automatic logic [31:0] ext_data(input logic [1:0] port, input logic [31:0] addr);
    return {8'hc5, 6'd0, port, 4'h0, addr[11:0]};
  endfunction

  // Bit 24 of port 0 picks clock B
  function automatic logic model_sync();
    if (gen_cfg_m[0][ntps_pkg::GEN_CFG_CLK_SEL_BIT]) begin
      return ntp_reg_m[7][0];
    end else begin
      return ntp_reg_m[3][0];
    end
  endfunction

  // Expected read data and pslverr for one address
  function automatic void ref_read(input logic [15:0] addr, output logic [31:0] rdata,
                                   output logic err);
    logic [2:0]  idx;
    logic [2:0]  np;
    logic [11:0] ofs;
    idx   = addr[14:12];
    ofs   = addr[11:0];
    np    = idx - 3'd2;
    rdata = '0;
    err   = 1'b0;
    if (idx >= 3'(ntps_pkg::NUM_SLAVES)) begin
      err = 1'b1;
    end else if (idx < 3'(ntps_pkg::SLV_NP0)) begin
      if (ofs[11:4] == 8'd0 && ofs[1:0] == 2'd0) begin
        rdata = ntp_reg_m[{idx[0], ofs[3:2]}];
      end
    end else if (ofs >= ntps_pkg::NP_EXT_BASE) begin
      // Responder flags an error on address bit 2
      rdata = ext_data(np[1:0], {20'd0, ofs});
      err   = ofs[2];
    end else if (ofs == ntps_pkg::NP_GEN_CONFIG) begin
      rdata = gen_cfg_m[np[1:0]];
    end else if (ofs == ntps_pkg::NP_STATUS) begin
      rdata = {31'd0, model_sync()};
    end
  endfunction

  function automatic void model_write(input logic [15:0] addr, input logic [31:0] wdata);
    logic [2:0]  idx;
    logic [2:0]  np;
    logic [11:0] ofs;
    idx = addr[14:12];
    ofs = addr[11:0];
    np  = idx - 3'd2;
    if (idx < 3'(ntps_pkg::SLV_NP0) && ofs[11:4] == 8'd0) begin
      ntp_reg_m[{idx[0], ofs[3:2]}] = wdata;
    end else if (idx < 3'(ntps_pkg::NUM_SLAVES) && ofs == ntps_pkg::NP_GEN_CONFIG) begin
      gen_cfg_m[np[1:0]] = wdata;
    end
  endfunction

  //------------------------------------------------
  // APB driver
  //------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata);
    apb_done_t rec;
    // Setup phase
    @(posedge clk156);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    // Access phase held until pready
    @(posedge clk156);
    #1;
    apb_req.penable = 1'b1;
    rec.waits       = 8'd0;
    @(negedge clk156);
    while (!apb_rsp.pready) begin
      rec.waits = rec.waits + 8'd1;
      @(negedge clk156);
    end
    rec.pwrite  = wr;
    rec.paddr   = addr;
    rec.pwdata  = wdata;
    rec.prdata  = apb_rsp.prdata;
    rec.pslverr = apb_rsp.pslverr;
    done_q.push_back(rec);
    // Completion edge
    @(posedge clk156);
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] wdata);
    apb_xfer(1'b1, addr, wdata);
  endtask

  task automatic apb_read(input logic [15:0] addr);
    apb_xfer(1'b0, addr, 32'd0);
  endtask

  // Select output checked after the two-cycle path
  task automatic check_select(input logic [63:0] exp_time, input logic exp_sync);
    repeat (2) @(posedge clk156);
    @(negedge clk156);
    if (ntp_time !== exp_time) begin
      err_cnt++;
      $display("ERR %0t: ntp_time %h, expected %h", $time, ntp_time, exp_time);
    end
    if (ntp_sync_ok !== exp_sync) begin
      err_cnt++;
      $display("ERR %0t: ntp_sync_ok %b, expected %b", $time, ntp_sync_ok, exp_sync);
    end
  endtask

  //------------------------------------------------
  // API responders for each port
  //------------------------------------------------
  for (genvar p = 0; p < ntps_pkg::NUM_PORTS; p++) begin : g_resp
    initial begin
      ext_seen_t seen;
      api_ext_rsp[p] = '{status: ntps_pkg::API_ST_BUSY, read_data: '0};
      forever begin
        @(negedge clk156);
        if (api_ext_req[p].command != ntps_pkg::API_CMD_IDLE) begin
          seen.port = 2'(p);
          seen.req  = api_ext_req[p];
          seen_q.push_back(seen);
          // Latency chosen by the stimulus
          repeat (resp_delay) @(posedge clk156);
          @(posedge clk156);
          #1;
          api_ext_rsp[p].read_data = ext_data(2'(p), api_ext_req[p].address);
          api_ext_rsp[p].status    = api_ext_req[p].address[2] ? ntps_pkg::API_ST_ERR
                                                              : ntps_pkg::API_ST_OK;
          // One status cycle before busy again
          @(posedge clk156);
          #1;
          api_ext_rsp[p] = '{status: ntps_pkg::API_ST_BUSY, read_data: '0};
        end
      end
    end
  end

  //------------------------------------------------
  // Comparison of completed accesses
  //------------------------------------------------
  initial begin
    apb_done_t   rec;
    ext_seen_t   seen;
    logic [31:0] exp_data;
    logic        exp_err;
    logic [2:0]  idx;
    logic [2:0]  np;
    logic [1:0]  exp_cmd;
    logic        ext_acc;
    forever begin
      @(negedge clk156);
      while (done_q.size() > 0) begin
        rec     = done_q.pop_front();
        idx     = rec.paddr[14:12];
        np      = idx - 3'd2;
        // Upper window of a network path goes out on the API port
        ext_acc = idx >= 3'(ntps_pkg::SLV_NP0) && idx < 3'(ntps_pkg::NUM_SLAVES) &&
                  rec.paddr[11:0] >= ntps_pkg::NP_EXT_BASE;
        chk_cnt++;
        ref_read(rec.paddr, exp_data, exp_err);
        if (rec.pslverr !== exp_err) begin
          err_cnt++;
          $display("ERR %0t: pslverr %b at %h, expected %b", $time, rec.pslverr, rec.paddr,
                   exp_err);
        end
        if (!rec.pwrite && rec.prdata !== exp_data) begin
          err_cnt++;
          $display("ERR %0t: read %h at %h, expected %h", $time, rec.prdata, rec.paddr,
                   exp_data);
        end
        // Registers and unmapped windows answer in the first access cycle
        if (!ext_acc && rec.waits != 8'd0) begin
          err_cnt++;
          $display("ERR %0t: access at %h took %0d wait states, expected none", $time,
                   rec.paddr, rec.waits);
        end
        if (ext_acc) begin
          exp_cmd = rec.pwrite ? ntps_pkg::API_CMD_WRITE : ntps_pkg::API_CMD_READ;
          if (seen_q.size() == 0) begin
            err_cnt++;
            $display("No API command was issued for the access at %h", rec.paddr);
          end else begin
            seen = seen_q.pop_front();
            if (seen.port !== np[1:0] || seen.req.command !== exp_cmd ||
                seen.req.address !== {20'd0, rec.paddr[11:0]} ||
                (rec.pwrite && seen.req.write_data !== rec.pwdata)) begin
              err_cnt++;
              $display("ERR %0t: API port %0d saw cmd %0d addr %h data %h for %h", $time,
                       seen.port, seen.req.command, seen.req.address, seen.req.write_data,
                       rec.paddr);
            end
          end
        end
        if (rec.pwrite) begin
          model_write(rec.paddr, rec.pwdata);
        end
      end
    end
  end

  //------------------------------------------------
  // Stimulus
  //------------------------------------------------
  initial begin
    logic [31:0] hi_a;
    logic [31:0] lo_a;
    logic [31:0] hi_b;
    logic [31:0] lo_b;
    logic [31:0] step;
    logic [31:0] v;
    logic [63:0] t0;
    logic [63:0] t1;
    logic [63:0] t2;
    logic [2:0]  idx;
    logic [11:0] ofs;
    int          assert_errs;
    void'($urandom(32'h0c07_d1c4));
    err_cnt    = 0;
    chk_cnt    = 0;
    resp_delay = 0;
    rst_n      = 1'b0;
    apb_req    = '0;
    for (int i = 0; i < ntps_pkg::NUM_PORTS; i++) begin
      gen_cfg_m[i] = '0;
    end
    for (int i = 0; i < 8; i++) begin
      ntp_reg_m[i] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk156);
    #1;
    rst_n = 1'b1;

    // Register readback with STEP held at zero
    for (int i = 0; i < ntps_pkg::NUM_PORTS; i++) begin
      apb_write(slv_addr(3'(ntps_pkg::SLV_NP0 + i), ntps_pkg::NP_GEN_CONFIG), $urandom());
    end
    for (int c = 0; c < 2; c++) begin
      apb_write(slv_addr(3'(c), ntps_pkg::NTP_TIME_HI), $urandom());
      apb_write(slv_addr(3'(c), ntps_pkg::NTP_TIME_LO), $urandom());
      apb_write(slv_addr(3'(c), ntps_pkg::NTP_STEP), 32'd0);
      apb_write(slv_addr(3'(c), ntps_pkg::NTP_CTRL), $urandom());
    end
    for (int i = 0; i < ntps_pkg::NUM_PORTS; i++) begin
      apb_read(slv_addr(3'(ntps_pkg::SLV_NP0 + i), ntps_pkg::NP_GEN_CONFIG));
      // STATUS is read only
      apb_write(slv_addr(3'(ntps_pkg::SLV_NP0 + i), ntps_pkg::NP_STATUS), $urandom());
      apb_read(slv_addr(3'(ntps_pkg::SLV_NP0 + i), ntps_pkg::NP_STATUS));
    end
    for (int c = 0; c < 2; c++) begin
      apb_read(slv_addr(3'(c), ntps_pkg::NTP_TIME_HI));
      apb_read(slv_addr(3'(c), ntps_pkg::NTP_TIME_LO));
      apb_read(slv_addr(3'(c), ntps_pkg::NTP_STEP));
      apb_read(slv_addr(3'(c), ntps_pkg::NTP_CTRL));
    end

    // Unmapped windows
    apb_read(slv_addr(3'd6, 12'h000));
    apb_read(slv_addr(3'd7, 12'h004));
    apb_write(slv_addr(3'd7, 12'h008), $urandom());

    // Clock select with A in sync and B not
    hi_a = $urandom() & 32'h7fff_ffff;
    lo_a = $urandom();
    hi_b = hi_a ^ 32'h0000_1000;
    lo_b = $urandom();
    apb_write(slv_addr(3'(ntps_pkg::SLV_NTPA), ntps_pkg::NTP_TIME_HI), hi_a);
    apb_write(slv_addr(3'(ntps_pkg::SLV_NTPA), ntps_pkg::NTP_TIME_LO), lo_a);
    apb_write(slv_addr(3'(ntps_pkg::SLV_NTPA), ntps_pkg::NTP_CTRL), 32'd1);
    apb_write(slv_addr(3'(ntps_pkg::SLV_NTPB), ntps_pkg::NTP_TIME_HI), hi_b);
    apb_write(slv_addr(3'(ntps_pkg::SLV_NTPB), ntps_pkg::NTP_TIME_LO), lo_b);
    apb_write(slv_addr(3'(ntps_pkg::SLV_NTPB), ntps_pkg::NTP_CTRL), 32'd0);
    apb_write(slv_addr(3'(ntps_pkg::SLV_NP0), ntps_pkg::NP_GEN_CONFIG), 32'd0);
    check_select({hi_a, lo_a}, 1'b1);
    for (int i = 0; i < ntps_pkg::NUM_PORTS; i++) begin
      apb_read(slv_addr(3'(ntps_pkg::SLV_NP0 + i), ntps_pkg::NP_STATUS));
    end
    apb_write(slv_addr(3'(ntps_pkg::SLV_NP0), ntps_pkg::NP_GEN_CONFIG),
              32'd1 << ntps_pkg::GEN_CFG_CLK_SEL_BIT);
    check_select({hi_b, lo_b}, 1'b0);
    for (int i = 0; i < ntps_pkg::NUM_PORTS; i++) begin
      apb_read(slv_addr(3'(ntps_pkg::SLV_NP0 + i), ntps_pkg::NP_STATUS));
    end

    // API extension with random port, offset, direction and latency
    for (int n = 0; n < N_EXT; n++) begin
      v          = $urandom_range(3, 0);
      idx        = 3'(ntps_pkg::SLV_NP0) + v[2:0];
      v          = $urandom_range(1023, 64);
      ofs        = {v[9:0], 2'b00};
      resp_delay = $urandom_range(7, 0);
      if ($urandom_range(1, 0) == 1) begin
        apb_write(slv_addr(idx, ofs), $urandom());
      end else begin
        apb_read(slv_addr(idx, ofs));
      end
    end

    // Timestamp advance on the selected clock B
    t0   = {hi_b, lo_b};
    step = ($urandom() >> 4) | 32'd1;
    apb_write(slv_addr(3'(ntps_pkg::SLV_NTPB), ntps_pkg::NTP_STEP), step);
    repeat (3) @(posedge clk156);
    @(negedge clk156);
    t1 = ntp_time;
    repeat (5) @(posedge clk156);
    @(negedge clk156);
    t2 = ntp_time;
    if (t1 == t0 || (t1 - t0) % {32'd0, step} != 64'd0) begin
      err_cnt++;
      $display("ERR %0t: time %h is no positive multiple of step %h past %h", $time, t1,
               step, t0);
    end
    if (t2 == t0 || (t2 - t0) % {32'd0, step} != 64'd0) begin
      err_cnt++;
      $display("ERR %0t: time %h is no positive multiple of step %h past %h", $time, t2,
               step, t0);
    end
    if (t2 <= t1) begin
      err_cnt++;
      $display("ERR %0t: time did not advance, %h then %h", $time, t1, t2);
    end

    // Let the comparison drain
    repeat (4) @(posedge clk156);
    if (seen_q.size() != 0) begin
      err_cnt++;
      $display("The API ports issued %0d commands that no access accounts for", seen_q.size());
    end
    assert_errs = DUT.g_np[0].g_sel_port.u_np.u_assert.fail_cnt
                + DUT.g_np[1].g_plain_port.u_np.u_assert.fail_cnt
                + DUT.g_np[2].g_plain_port.u_np.u_assert.fail_cnt
                + DUT.g_np[3].g_plain_port.u_np.u_assert.fail_cnt;
    $display("accesses checked: %0d, errors: %0d, assertion failures: %0d", chk_cnt, err_cnt,
             assert_errs);
    if (err_cnt == 0 && assert_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  //------------------------------------------------
  // Watchdog
  //------------------------------------------------
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

//--- vlog.f
source/ntps_pkg.sv
source/apb_slave_decoder.sv
source/ntp_clock_core.sv
source/ntp_clock_select.sv
source/network_path_regs.sv
source/ntps_interfaces.sv
tests/ntps_assert.sv
tests/tb_ntps_interfaces.sv
